//--- Bender.yml
package:
  name: srpt_grant

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/srpt_pkg.sv
      - src/srpt_sort_pair.sv
      - src/srpt_queue.sv
      - src/srpt_grant_sched.sv
      - src/srpt_grant_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - bench/srpt_grant_tb.sv

//--- bench/srpt_grant_tb.sv
`include "srpt_params.svh"

module srpt_grant_tb;

   localparam int TABLE_LEN       = 14;
   localparam int DRAIN_LIMIT     = 64;
   localparam int RANDOM_CYCLES   = 400;
   // Kept well under the queue depth
   localparam int MAX_OUTSTANDING = 10;

   // One table row, a header and whether it should enter the queue
   typedef struct packed {
      srpt_pkg::srpt_hdr_t hdr;
      logic                push;
   } stim_t;

   logic                  ap_clk;
   logic                  ap_rst;
   logic                  hdr_valid_i;
   srpt_pkg::srpt_hdr_t   hdr_i;
   logic                  grant_full_i;
   logic                  grant_valid_o;
   srpt_pkg::srpt_entry_t grant_o;

   stim_t                 stim_table [TABLE_LEN];
   // Reference model of the queued entries, unordered
   srpt_pkg::srpt_entry_t model_q [$];
   // Grantable values already handed out
   bit                    used_grantable [1024];
   // Grant decided in the previous cycle
   logic                  exp_valid;
   srpt_pkg::srpt_entry_t exp_grant;

   srpt_grant_top i_dut (
      .ap_clk        (ap_clk),
      .ap_rst        (ap_rst),
      .hdr_valid_i   (hdr_valid_i),
      .hdr_i         (hdr_i),
      .grant_full_i  (grant_full_i),
      .grant_valid_o (grant_valid_o),
      .grant_o       (grant_o)
   );

   always #20 ap_clk = ~ap_clk;

   task automatic fail_value(input string msg);
      $display("FAILED at time %0t: %s", $time, msg);
      $display("sim failed");
      $fatal(1, "wrong value from the DUT");
   endtask

   task automatic fail_plain(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_grant(input srpt_pkg::srpt_entry_t exp);
      if (grant_valid_o !== 1'b1) begin
         fail_value($sformatf("no grant, expected peer %0d rpc %0d grantable %0d",
                              exp.peer_id, exp.rpc_id, exp.grantable));
      end else if (grant_o !== exp) begin
         fail_value($sformatf("grant peer %0d rpc %0d grantable %0d, expected %0d %0d %0d",
                              grant_o.peer_id, grant_o.rpc_id, grant_o.grantable,
                              exp.peer_id, exp.rpc_id, exp.grantable));
      end
   endtask

   task automatic check_no_grant();
      if (grant_valid_o !== 1'b0) begin
         fail_value($sformatf("unexpected grant peer %0d rpc %0d grantable %0d",
                              grant_o.peer_id, grant_o.rpc_id, grant_o.grantable));
      end
   endtask

   // First packet of a message with bytes left to grant
   function automatic bit insert_rule(input srpt_pkg::srpt_hdr_t hdr);
      return (hdr.offset == 0) && (hdr.msg_len > hdr.incoming);
   endfunction

   function automatic srpt_pkg::srpt_entry_t make_entry(input srpt_pkg::srpt_hdr_t hdr);
      srpt_pkg::srpt_entry_t e;
      logic [`SRPT_LEN_W-1:0] remain;
      remain      = hdr.msg_len - hdr.incoming;
      e.peer_id   = hdr.peer_id;
      e.rpc_id    = hdr.rpc_id;
      e.grantable = remain[`SRPT_GRANTABLE_W-1:0];
      e.state     = srpt_pkg::SRPT_ACTIVE;
      return e;
   endfunction

   // One clock cycle of stimulus, output check and model update
   task automatic step(input logic valid, input srpt_pkg::srpt_hdr_t hdr,
                       input logic push, input logic full);
      int best;
      @(posedge ap_clk);
      hdr_valid_i  <= valid;
      hdr_i        <= hdr;
      grant_full_i <= full;
      @(negedge ap_clk);
      // Outputs now show the decision of the previous cycle
      if (exp_valid) begin
         check_grant(exp_grant);
      end else begin
         check_no_grant();
      end
      exp_valid = 1'b0;
      if (valid) begin
         if (push) begin
            model_q.push_back(make_entry(hdr));
         end
      end else if (!full && model_q.size() > 0) begin
         // Fewest grantable bytes goes first
         best = 0;
         for (int i = 1; i < model_q.size(); i++) begin
            if (model_q[i].grantable < model_q[best].grantable) begin
               best = i;
            end
         end
         exp_grant = model_q[best];
         exp_valid = 1'b1;
         model_q.delete(best);
      end
   endtask

   task automatic drain_queue();
      int waited;
      waited = 0;
      while (model_q.size() > 0 || exp_valid) begin
         if (waited == DRAIN_LIMIT) begin
            fail_plain("Queue did not drain within the cycle limit");
         end
         step(1'b0, '0, 1'b0, 1'b0);
         waited++;
      end
   endtask

   task automatic set_row(input int idx, input int peer, input int rpc, input int msg_len,
                          input int incoming, input int offset, input logic push);
      stim_table[idx].hdr.peer_id  = peer;
      stim_table[idx].hdr.rpc_id   = rpc;
      stim_table[idx].hdr.msg_len  = msg_len;
      stim_table[idx].hdr.incoming = incoming;
      stim_table[idx].hdr.offset   = offset;
      stim_table[idx].push         = push;
      if (push) begin
         used_grantable[msg_len - incoming] = 1'b1;
      end
   endtask

   // Distinct grantables, plus rows that must be filtered out
   task automatic fill_table();
      set_row(0,  1,  10, 5000, 4200, 0,    1'b1);
      set_row(1,  2,  11, 3000, 2700, 0,    1'b1);
      set_row(2,  3,  12, 9000, 8100, 0,    1'b1);
      set_row(3,  4,  13, 1500, 1450, 0,    1'b1);
      // Equal length and incoming
      set_row(4,  5,  14, 2000, 2000, 0,    1'b0);
      set_row(5,  6,  15, 7000, 6400, 0,    1'b1);
      // Not the first packet
      set_row(6,  7,  16, 4000, 3000, 1400, 1'b0);
      set_row(7,  8,  17, 2500, 2380, 0,    1'b1);
      // All bytes already unscheduled
      set_row(8,  9,  18, 1000, 1800, 0,    1'b0);
      set_row(9,  10, 19, 6000, 5550, 0,    1'b1);
      set_row(10, 11, 20, 3300, 3299, 0,    1'b1);
      set_row(11, 12, 21, 8000, 7023, 0,    1'b1);
      set_row(12, 13, 22, 5200, 4500, 1400, 1'b0);
      set_row(13, 14, 23, 4400, 4190, 0,    1'b1);
   endtask

   task automatic random_header(output srpt_pkg::srpt_hdr_t hdr);
      int unsigned kind;
      int unsigned g;
      kind         = $urandom_range(0, 7);
      hdr.peer_id  = $urandom_range(0, 16383);
      hdr.rpc_id   = $urandom_range(0, 16383);
      hdr.incoming = $urandom_range(1000, 200000);
      hdr.offset   = '0;
      if (kind == 0) begin
         hdr.msg_len = hdr.incoming + $urandom_range(1, 1023);
         hdr.offset  = $urandom_range(1, 60000);
      end else if (kind == 1) begin
         hdr.msg_len = hdr.incoming - $urandom_range(0, 500);
      end else begin
         // Next free grantable so no two entries tie
         g = $urandom_range(1, 1023);
         while (used_grantable[g]) begin
            g = (g % 1023) + 1;
         end
         used_grantable[g] = 1'b1;
         hdr.msg_len = hdr.incoming + g;
      end
   endtask

   initial begin
      srpt_pkg::srpt_hdr_t hdr;
      ap_clk       = 1'b0;
      ap_rst       = 1'b1;
      hdr_valid_i  = 1'b0;
      hdr_i        = '0;
      grant_full_i = 1'b0;
      exp_valid    = 1'b0;
      void'($urandom(32'h2385));
      fill_table();

      repeat (10) @(posedge ap_clk);
      ap_rst <= 1'b0;

      // Idle after reset, nothing to grant
      repeat (20) step(1'b0, '0, 1'b0, 1'b0);

      // Whole table back to back while the grant FIFO is full
      for (int i = 0; i < TABLE_LEN; i++) begin
         step(1'b1, stim_table[i].hdr, stim_table[i].push, 1'b1);
      end
      repeat (3) step(1'b0, '0, 1'b0, 1'b1);
      drain_queue();

      // Back-pressure in the middle of a drain
      for (int i = 0; i < 6; i++) begin
         step(1'b1, stim_table[i].hdr, stim_table[i].push, 1'b0);
      end
      repeat (2) step(1'b0, '0, 1'b0, 1'b0);
      repeat (4) step(1'b0, '0, 1'b0, 1'b1);
      drain_queue();

      // Random headers, idle cycles and back-pressure
      for (int c = 0; c < RANDOM_CYCLES; c++) begin
         if ($urandom_range(0, 9) < 4 && model_q.size() < MAX_OUTSTANDING) begin
            random_header(hdr);
            step(1'b1, hdr, insert_rule(hdr), $urandom_range(0, 4) == 0);
         end else begin
            step(1'b0, '0, 1'b0, $urandom_range(0, 4) == 0);
         end
      end
      drain_queue();

      $display("sim passed");
      $finish;
   end

endmodule

//--- src/srpt_grant_sched.sv
`include "srpt_params.svh"

module srpt_grant_sched (
   input  logic                  ap_clk,
   input  logic                  ap_rst,
   input  logic                  hdr_valid_i,
   input  srpt_pkg::srpt_hdr_t   hdr_i,
   input  logic                  grant_full_i,
   input  srpt_pkg::srpt_entry_t head_i,
   output logic                  push_o,
   output srpt_pkg::srpt_entry_t push_entry_o,
   output logic                  pop_o,
   output logic                  grant_valid_o,
   output srpt_pkg::srpt_entry_t grant_o
);

   // Bytes beyond the unscheduled part
   logic [`SRPT_LEN_W-1:0] hdr_remain;
   // Header opens a message
   logic                   hdr_first;
   // Message still needs grants
   logic                   hdr_needs_grant;
   // Head holds a grantable entry
   logic                   head_active;

   assign hdr_remain      = hdr_i.msg_len - hdr_i.incoming;
   assign hdr_first       = (hdr_i.offset == '0);
   assign hdr_needs_grant = (hdr_i.msg_len > hdr_i.incoming);
   assign head_active     = (head_i.state == srpt_pkg::SRPT_ACTIVE);

   // Only the first packet of a message creates an entry
   assign push_o = hdr_valid_i && hdr_first && hdr_needs_grant;

   // New entry from the header fields
   // Grantable keeps the low bits of the remaining length
   always_comb begin
      push_entry_o.peer_id   = hdr_i.peer_id;
      push_entry_o.rpc_id    = hdr_i.rpc_id;
      push_entry_o.grantable = hdr_remain[`SRPT_GRANTABLE_W-1:0];
      push_entry_o.state     = srpt_pkg::SRPT_ACTIVE;
   end

   // Headers win over grants
   // A full grant FIFO holds everything in the queue
   assign pop_o = !hdr_valid_i && !grant_full_i && head_active;

   // Grant strobe for one cycle after the decision
   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         grant_valid_o <= 1'b0;
      end else begin
         grant_valid_o <= pop_o;
      end
   end

   // Popped head is captured as the grant
   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         grant_o <= '0;
      end else if (pop_o) begin
         grant_o <= head_i;
      end
   end

   // Each grant is an active entry
   a_grant_active : assert property (@(posedge ap_clk) disable iff (ap_rst)
      grant_valid_o |-> (grant_o.state == srpt_pkg::SRPT_ACTIVE));

endmodule

//--- src/srpt_grant_top.sv
`include "srpt_params.svh"

module srpt_grant_top (
   input  logic                  ap_clk,
   input  logic                  ap_rst,
   input  logic                  hdr_valid_i,
   input  srpt_pkg::srpt_hdr_t   hdr_i,
   input  logic                  grant_full_i,
   output logic                  grant_valid_o,
   output srpt_pkg::srpt_entry_t grant_o
);

   // Scheduler to queue
   logic                  push;
   srpt_pkg::srpt_entry_t push_entry;
   logic                  pop;

   // Queue to scheduler, combinational head view
   srpt_pkg::srpt_entry_t head;

   // Header filtering and grant issue
   srpt_grant_sched i_sched (
      .ap_clk        (ap_clk),
      .ap_rst        (ap_rst),
      .hdr_valid_i   (hdr_valid_i),
      .hdr_i         (hdr_i),
      .grant_full_i  (grant_full_i),
      .head_i        (head),
      .push_o        (push),
      .push_entry_o  (push_entry),
      .pop_o         (pop),
      .grant_valid_o (grant_valid_o),
      .grant_o       (grant_o)
   );

   // Sorted entry storage
   srpt_queue #(
      .DEPTH (`SRPT_DEPTH)
   ) i_queue (
      .ap_clk       (ap_clk),
      .ap_rst       (ap_rst),
      .push_i       (push),
      .push_entry_i (push_entry),
      .pop_i        (pop),
      .head_o       (head)
   );

endmodule

//--- src/srpt_params.svh
`ifndef SRPT_PARAMS_SVH
`define SRPT_PARAMS_SVH

// Peer identifier carried in every header and queue entry
`define SRPT_PEER_ID_W 14

// RPC identifier within one peer
`define SRPT_RPC_ID_W 14

// Bytes still to be granted, kept narrow to keep the compare short
`define SRPT_GRANTABLE_W 10

// Entry state code, wide enough for the full receiver encoding
`define SRPT_STATE_W 3

// Message length, incoming and offset fields of a data header
`define SRPT_LEN_W 32

// Number of positions in the sorted queue
`define SRPT_DEPTH 16

`endif

//--- src/srpt_pkg.sv
`include "srpt_params.svh"

package srpt_pkg;

   // Entry state codes
   // A higher code ranks nearer the head of the queue
   typedef enum logic [`SRPT_STATE_W-1:0] {
      SRPT_EMPTY  = 3'd4,
      SRPT_ACTIVE = 3'd6
   } srpt_state_e;

   // One queue entry, 41 bits
   // Peer in the top bits, state code in the bottom bits
   typedef struct packed {
      logic [`SRPT_PEER_ID_W-1:0]   peer_id;
      logic [`SRPT_RPC_ID_W-1:0]    rpc_id;
      logic [`SRPT_GRANTABLE_W-1:0] grantable;
      srpt_state_e                  state;
   } srpt_entry_t;

   // Data packet header as seen by the scheduler, 124 bits
   typedef struct packed {
      logic [`SRPT_PEER_ID_W-1:0] peer_id;
      logic [`SRPT_RPC_ID_W-1:0]  rpc_id;
      // Total message length in bytes
      logic [`SRPT_LEN_W-1:0]     msg_len;
      // Bytes the sender may push without a grant
      logic [`SRPT_LEN_W-1:0]     incoming;
      // Byte offset of this packet in the message
      logic [`SRPT_LEN_W-1:0]     offset;
   } srpt_hdr_t;

endpackage

//--- src/srpt_queue.sv
`include "srpt_params.svh"

module srpt_queue #(
   parameter int DEPTH = `SRPT_DEPTH
) (
   input  logic                  ap_clk,
   input  logic                  ap_rst,
   input  logic                  push_i,
   input  srpt_pkg::srpt_entry_t push_entry_i,
   input  logic                  pop_i,
   output srpt_pkg::srpt_entry_t head_o
);

   // Filler for unused positions and for the pop input
   localparam srpt_pkg::srpt_entry_t EMPTY_ENTRY = '{
      peer_id:   '0,
      rpc_id:    '0,
      grantable: '0,
      state:     srpt_pkg::SRPT_EMPTY
   };

   // Stored positions, 0 is the head
   srpt_pkg::srpt_entry_t q_r [DEPTH];

   // Incoming entry followed by every stored position
   srpt_pkg::srpt_entry_t chain_w [DEPTH+1];
   // Results after the even layer, one position further down
   srpt_pkg::srpt_entry_t even_w [DEPTH+1];
   // Results after the odd layer
   srpt_pkg::srpt_entry_t odd_w [DEPTH+1];

   genvar k;

   // An EMPTY entry enters on pop
   // It ranks below every active entry and sinks toward the tail
   assign chain_w[0] = push_i ? push_entry_i : EMPTY_ENTRY;

   for (k = 0; k < DEPTH; k++) begin : g_chain
      assign chain_w[k+1] = q_r[k];
   end

   // Even layer
   // Pair 0 meets the incoming entry with the head
   // Later pairs join each odd position with the even one below it
   for (k = 0; k < DEPTH/2; k++) begin : g_even
      srpt_sort_pair i_pair (
         .upper_i (chain_w[2*k]),
         .lower_i (chain_w[2*k+1]),
         .upper_o (even_w[2*k]),
         .lower_o (even_w[2*k+1])
      );
   end

   // Old tail has no partner in the even layer
   assign even_w[DEPTH] = chain_w[DEPTH];

   // Odd layer, offset by one position
   assign odd_w[0] = even_w[0];

   for (k = 0; k < DEPTH/2; k++) begin : g_odd
      srpt_sort_pair i_pair (
         .upper_i (even_w[2*k+1]),
         .lower_i (even_w[2*k+2]),
         .upper_o (odd_w[2*k+1]),
         .lower_o (odd_w[2*k+2])
      );
   end

   // Push keeps the top DEPTH results and drops whatever falls off the tail
   // Pop drops the old head and shifts everything up by one
   always_ff @(posedge ap_clk) begin
      if (ap_rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            q_r[i] <= EMPTY_ENTRY;
         end
      end else if (push_i) begin
         for (int i = 0; i < DEPTH; i++) begin
            q_r[i] <= odd_w[i];
         end
      end else if (pop_i) begin
         for (int i = 0; i < DEPTH; i++) begin
            q_r[i] <= odd_w[i+1];
         end
      end
   end

   assign head_o = q_r[0];

   // Scheduler must never push and pop in the same cycle
   a_push_pop_excl : assert property (@(posedge ap_clk) disable iff (ap_rst)
      !(push_i && pop_i));

   // Pops only remove real entries
   a_pop_not_empty : assert property (@(posedge ap_clk) disable iff (ap_rst)
      pop_i |-> (head_o.state != srpt_pkg::SRPT_EMPTY));

endmodule

//--- src/srpt_sort_pair.sv
module srpt_sort_pair (
   input  srpt_pkg::srpt_entry_t upper_i,
   input  srpt_pkg::srpt_entry_t lower_i,
   output srpt_pkg::srpt_entry_t upper_o,
   output srpt_pkg::srpt_entry_t lower_o
);

   // High when the lower entry must move up
   logic lower_wins;
   // State codes differ between the two entries
   logic state_differs;

   // State decides first
   assign state_differs = (lower_i.state != upper_i.state);

   // Fewer grantable bytes win on equal state
   // On a full tie the upper entry keeps its place
   always_comb begin
      if (state_differs) begin
         lower_wins = (lower_i.state > upper_i.state);
      end else begin
         lower_wins = (lower_i.grantable < upper_i.grantable);
      end
   end

   // Exchange or pass straight through
   always_comb begin
      if (lower_wins) begin
         upper_o = lower_i;
         lower_o = upper_i;
      end else begin
         upper_o = upper_i;
         lower_o = lower_i;
      end
   end

endmodule

//--- tb.f
+incdir+src
src/srpt_pkg.sv
src/srpt_sort_pair.sv
src/srpt_queue.sv
src/srpt_grant_sched.sv
src/srpt_grant_top.sv
bench/srpt_grant_tb.sv
